// ==== lsuOpPkg.sv ====
`default_nettype none

package lsuOpPkg;

  localparam int DataW     = 64;         // XLEN, also the RAM line width
  localparam int ByteLanes = DataW / 8;  // 8 lanes per line

  // loads carry width in bits 1:0 and unsigned in bit 2, stores use only the width
  typedef enum logic [2:0] {
    opLb  = 3'd0,
    opLh  = 3'd1,
    opLw  = 3'd2,
    opLd  = 3'd3,
    opLbu = 3'd4,
    opLhu = 3'd5,
    opLwu = 3'd6
  } memOp_e;

  function automatic logic [1:0] opSize(memOp_e op);
    return op[1:0];  // 0 byte, 1 half, 2 word, 3 double
  endfunction

  function automatic logic opUnsigned(memOp_e op);
    return op[2];
  endfunction

  function automatic logic isMisaligned(memOp_e op, logic [2:0] off);
    case (opSize(op))
      2'd0:    return 1'b0;        // bytes can sit anywhere
      2'd1:    return off[0];
      2'd2:    return |off[1:0];
      default: return |off;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== lsuBusPkg.sv ====
`default_nettype none

package lsuBusPkg;

  import lsuOpPkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // core side request and response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [DataW-1:0] addr;    // full byte address, line index from bit 3 up
    memOp_e           op;      // width and sign code
    logic             isStore;
    logic [DataW-1:0] wrData;  // store data, low bits hold the value
  } lsuReq_t;

  typedef struct packed {
    logic [DataW-1:0] rdData;  // extended load value, zero for stores and errors
    logic             error;   // access was misaligned and refused
  } lsuRsp_t;

endpackage

`default_nettype wire

// ==== lsuCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuCtrl import lsuOpPkg::*, lsuBusPkg::*; #(
  parameter int AddrW = 8
) (
  input  logic             clk,
  input  logic             rstN,
  input  lsuReq_t          req,
  input  logic             reqValid,
  input  logic [DataW-1:0] ldValue,
  output logic             busy,
  output lsuRsp_t          rsp,
  output logic             rspValid,
  output logic             ramEn,
  output logic             ramWe,
  output logic [AddrW-1:0] ramAddr,
  output lsuReq_t          curReq
);

  typedef enum logic [1:0] {sIdle, sLoadWait, sStoreRead, sStoreWrite} state_e;

  state_e state;
  logic   rspErr;
  logic   accept;
  logic   misal;

  assign accept = reqValid && !busy;
  assign misal  = isMisaligned(req.op, req.addr[2:0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= sIdle;
      rspValid <= 1'b0;
      rspErr   <= 1'b0;
    end else begin
      rspValid <= 1'b0;
      case (state)
        sIdle: begin
          if (accept) begin
            rspErr <= misal;
            if (misal) rspValid <= 1'b1;  // refused, answer right away
            else if (req.isStore) state <= sStoreRead;
            else state <= sLoadWait;
          end
        end
        sLoadWait: begin
          state    <= sIdle;
          rspValid <= 1'b1;
        end
        sStoreRead: state <= sStoreWrite;  // old line lands in rdLine here
        sStoreWrite: begin
          state    <= sIdle;
          rspValid <= 1'b1;
        end
        default: state <= sIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) curReq <= req;  // held until the next acceptance
  end

  assign busy    = (state != sIdle);
  assign ramEn   = (state == sLoadWait) || (state == sStoreRead) || (state == sStoreWrite);
  assign ramWe   = (state == sStoreWrite);
  assign ramAddr = curReq.addr[AddrW+2:3];

  always_comb begin
    rsp.error  = rspErr;
    rsp.rdData = (rspValid && !rspErr && !curReq.isStore) ? ldValue : '0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // protocol checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  noReqWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
    busy |-> !reqValid);

  // a refused access must answer with error and leave the RAM alone
  misalNoRam: assert property (@(posedge clk) disable iff (!rstN)
    accept && misal |=> rspValid && rsp.error && !ramEn && !ramWe);

  rspOnePulse: assert property (@(posedge clk) disable iff (!rstN)
    rspValid && !accept |=> !rspValid);

endmodule

`default_nettype wire

// ==== loadAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadAlign import lsuOpPkg::*; (
  input  logic [DataW-1:0] line,
  input  memOp_e           op,
  input  logic [2:0]       byteOff,
  output logic [DataW-1:0] value
);

  logic [7:0]  bSel;
  logic [15:0] hSel;
  logic [31:0] wSel;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // field select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign bSel = line[{byteOff, 3'b000} +: 8];         // any of the eight lanes
  assign hSel = line[{byteOff[2:1], 4'b0000} +: 16];  // low offset bit ignored
  assign wSel = line[{byteOff[2], 5'b00000} +: 32];   // lower or upper word

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sign or zero extension
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (opSize(op))
      2'd0: begin
        if (opUnsigned(op)) value = {56'h0, bSel};
        else value = {{56{bSel[7]}}, bSel};
      end
      2'd1: begin
        if (opUnsigned(op)) value = {48'h0, hSel};
        else value = {{48{hSel[15]}}, hSel};
      end
      2'd2: begin
        if (opUnsigned(op)) value = {32'h0, wSel};
        else value = {{32{wSel[31]}}, wSel};
      end
      default: value = line;  // ld takes the whole line
    endcase
  end

endmodule

`default_nettype wire

// ==== storeMerge.sv ====
`timescale 1ns/1ps
`default_nettype none

module storeMerge import lsuOpPkg::*; (
  input  logic [DataW-1:0] oldLine,
  input  logic [DataW-1:0] wrData,
  input  logic [1:0]       size,
  input  logic [2:0]       byteOff,
  output logic [DataW-1:0] newLine
);

  logic [DataW-1:0]     spread;  // store value repeated over the line
  logic [ByteLanes-1:0] mask;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // replicate data and build the lane mask
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (size)
      2'd0: begin
        spread = {8{wrData[7:0]}};
        mask   = 8'h01 << byteOff;
      end
      2'd1: begin
        spread = {4{wrData[15:0]}};
        mask   = 8'h03 << {byteOff[2:1], 1'b0};
      end
      2'd2: begin
        spread = {2{wrData[31:0]}};
        mask   = 8'h0f << {byteOff[2], 2'b00};
      end
      default: begin
        spread = wrData;
        mask   = 8'hff;
      end
    endcase
  end

  // each lane takes the new byte if masked, else keeps the old one
  always_comb begin
    for (int i = 0; i < ByteLanes; i++) begin
      newLine[i*8 +: 8] = mask[i] ? spread[i*8 +: 8] : oldLine[i*8 +: 8];
    end
  end

  // inputs are undefined before the first request
  always_comb begin
    if (!$isunknown({size, byteOff})) begin
      maskWidth: assert final ($countones(mask) == (1 << size) && mask[byteOff])
        else $error("storeMerge mask %b does not match size %0d at lane %0d",
                    mask, size, byteOff);
    end
  end

endmodule

`default_nettype wire

// ==== dataRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataRam import lsuOpPkg::*; #(
  parameter int AddrW = 8
) (
  input  logic             clk,
  input  logic             en,
  input  logic             we,
  input  logic [AddrW-1:0] addr,
  input  logic [DataW-1:0] wrLine,
  output logic [DataW-1:0] rdLine
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [DataW-1:0] mem [2**AddrW];

  // rdLine holds across the write cycle so the merge input stays stable
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wrLine;
      end else begin
        rdLine <= mem[addr];  // registered read, ready one cycle after en
      end
    end
  end

endmodule

`default_nettype wire

// ==== lsuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTop import lsuOpPkg::*, lsuBusPkg::*; #(
  parameter int AddrW = 8
) (
  input  logic    clk,
  input  logic    rstN,
  input  lsuReq_t req,
  input  logic    reqValid,
  output lsuRsp_t rsp,
  output logic    rspValid,
  output logic    busy
);

  lsuReq_t          curReq;
  logic             ramEn;
  logic             ramWe;
  logic [AddrW-1:0] ramAddr;
  logic [DataW-1:0] rdLine;
  logic [DataW-1:0] wrLine;
  logic [DataW-1:0] ldValue;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control and storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  lsuCtrl #(.AddrW(AddrW)) uCtrl (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .reqValid (reqValid),
    .ldValue  (ldValue),
    .busy     (busy),
    .rsp      (rsp),
    .rspValid (rspValid),
    .ramEn    (ramEn),
    .ramWe    (ramWe),
    .ramAddr  (ramAddr),
    .curReq   (curReq)
  );

  dataRam #(.AddrW(AddrW)) uRam (
    .clk    (clk),
    .en     (ramEn),
    .we     (ramWe),
    .addr   (ramAddr),
    .wrLine (wrLine),
    .rdLine (rdLine)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath, both sides work off the registered request
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  loadAlign uLoadAlign (
    .line    (rdLine),
    .op      (curReq.op),
    .byteOff (curReq.addr[2:0]),
    .value   (ldValue)
  );

  storeMerge uStoreMerge (
    .oldLine (rdLine),
    .wrData  (curReq.wrData),
    .size    (opSize(curReq.op)),
    .byteOff (curReq.addr[2:0]),
    .newLine (wrLine)
  );

endmodule

`default_nettype wire

// ==== tb_lsuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsuTop import lsuOpPkg::*, lsuBusPkg::*;;

  localparam int NumTests   = 6;
  localparam int OpsPerTest = 240;  // largest test is the 200 access mix plus its prefill
  localparam int CycleNs    = 10;

  logic    clk = 1'b0;
  logic    rstN = 1'b0;
  lsuReq_t req = '0;
  logic    reqValid = 1'b0;
  lsuRsp_t rsp;
  logic    rspValid;
  logic    busy;

  logic [63:0] refMem [256];  // model of the RAM lines
  logic [63:0] expRdData = '0;
  logic        expError = 1'b0;
  logic        started = 1'b0;
  logic        acceptOk;
  logic        acceptBad;
  int          seed = 64;
  int          errCount = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;

  lsuTop #(.AddrW(8)) u_dut (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .reqValid (reqValid),
    .rsp      (rsp),
    .rspValid (rspValid),
    .busy     (busy)
  );

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic alignFault(logic [2:0] op, logic [2:0] off);
    int bytes;
    bytes = 1 << op[1:0];
    return (off % bytes) != 0;  // offset must be a multiple of the access size
  endfunction

  function automatic logic [63:0] extendLoad(logic [63:0] line, logic [2:0] op, logic [2:0] off);
    logic [63:0] field;
    logic [63:0] keep;
    int          bits;
    field = line >> (8 * off);
    bits = 8 << op[1:0];
    if (bits == 64) return field;
    keep = (64'd1 << bits) - 1;
    field = field & keep;
    if (!op[2] && field[bits-1]) field = field | ~keep;  // signed codes copy the top bit up
    return field;
  endfunction

  function automatic logic [63:0] mergeLine(logic [63:0] old, logic [63:0] data,
                                            logic [1:0] size, logic [2:0] off);
    logic [63:0] line;
    line = old;
    for (int i = 0; i < (1 << size); i++) begin
      line[8 * (off + i) +: 8] = data[8 * i +: 8];
    end
    return line;
  endfunction

  function automatic logic [63:0] lineAddr(logic [7:0] idx, logic [2:0] off);
    return {53'd0, idx, off};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign acceptOk  = reqValid && !busy && !alignFault(req.op, req.addr[2:0]);
  assign acceptBad = reqValid && !busy && alignFault(req.op, req.addr[2:0]);

  idleAfterReset: assert property (@(posedge clk) disable iff (!rstN)
    !started |-> !busy && !rspValid)
    else begin
      $display("busy or rspValid went high before any request at %0t", $time);
      errCount++;
    end

  loadTiming: assert property (@(posedge clk) disable iff (!rstN)
    acceptOk && !req.isStore |=> busy && !rspValid ##1 !busy && rspValid)
    else begin
      $display("load response not 1 cycle after acceptance at %0t", $time);
      errCount++;
    end

  storeTiming: assert property (@(posedge clk) disable iff (!rstN)
    acceptOk && req.isStore |=> busy && !rspValid ##1 busy && !rspValid ##1 !busy && rspValid)
    else begin
      $display("store response not 2 cycles after acceptance at %0t", $time);
      errCount++;
    end

  misalTiming: assert property (@(posedge clk) disable iff (!rstN)
    acceptBad |=> rspValid && !busy)
    else begin
      $display("misaligned access not refused in the next cycle at %0t", $time);
      errCount++;
    end

  dataMatch: assert property (@(posedge clk) disable iff (!rstN)
    rspValid |-> rsp.rdData == expRdData)
    else begin
      $display("** Error at %0t: rsp.rdData expected %h actual %h", $time,
               $sampled(expRdData), $sampled(rsp.rdData));
      errCount++;
    end

  errorMatch: assert property (@(posedge clk) disable iff (!rstN)
    rspValid |-> rsp.error == expError)
    else begin
      $display("** Error at %0t: rsp.error expected %b actual %b", $time,
               $sampled(expError), $sampled(rsp.error));
      errCount++;
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one access from strobe to response, the model follows legal stores
  task automatic runAccess(input logic [63:0] addr, input logic [2:0] op,
                           input logic isStore, input logic [63:0] data);
    logic [7:0] idx;
    logic [2:0] off;
    logic       bad;
    int         waitCycles;
    idx = addr[10:3];
    off = addr[2:0];
    bad = alignFault(op, off);
    @(posedge clk);
    req       <= '{addr: addr, op: memOp_e'(op), isStore: isStore, wrData: data};
    reqValid  <= 1'b1;
    started   <= 1'b1;
    expError  <= bad;
    expRdData <= (bad || isStore) ? 64'd0 : extendLoad(refMem[idx], op, off);
    if (!bad && isStore) refMem[idx] = mergeLine(refMem[idx], data, op[1:0], off);
    @(posedge clk);
    reqValid <= 1'b0;
    waitCycles = 0;
    @(negedge clk);
    while (!rspValid && waitCycles < 8) begin
      @(negedge clk);
      waitCycles++;
    end
    if (!rspValid) begin
      $display("no response to access at address %h op %0d", addr, op);
      errCount++;
    end
  endtask

  task automatic reportTest(input string name, input int errsBefore);
    if (errCount == errsBefore) begin
      $display("test %s: ok", name);
      testsPassed++;
    end else begin
      $display("test %s: FAILED with %0d errors", name, errCount - errsBefore);
      testsFailed++;
    end
  endtask

  initial begin
    #(NumTests * OpsPerTest * 3 * CycleNs + 2000);
    $display("run timed out at %0t before all tests finished", $time);
    $display("sim failed");
    $finish;
  end

  initial begin
    logic [63:0] pattern;
    logic        isSt;
    int          errsBefore;
    int          op;
    int          off;
    int          idx;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;

    errsBefore = errCount;
    repeat (4) @(posedge clk);  // nothing may happen without a strobe
    reportTest("idle after reset", errsBefore);

    errsBefore = errCount;
    pattern = {$random(seed), $random(seed)};
    runAccess(lineAddr(8'd5, 3'd0), 3'd3, 1'b1, pattern);
    runAccess(lineAddr(8'd5, 3'd0), 3'd3, 1'b0, 64'd0);
    reportTest("sd then ld", errsBefore);

    errsBefore = errCount;
    for (int sz = 0; sz < 3; sz++) begin
      runAccess(lineAddr(8'(16 + sz), 3'd0), 3'd3, 1'b1, {$random(seed), $random(seed)});
      for (off = 0; off < 8; off += (1 << sz)) begin
        runAccess(lineAddr(8'(16 + sz), 3'(off)), 3'(sz), 1'b1, {$random(seed), $random(seed)});
        runAccess(lineAddr(8'(16 + sz), 3'd0), 3'd3, 1'b0, 64'd0);
      end
    end
    reportTest("partial stores", errsBefore);

    errsBefore = errCount;
    pattern = 64'hf877_e65d_c433_a291;  // both sign cases show up across the two passes
    for (int pass = 0; pass < 2; pass++) begin
      runAccess(lineAddr(8'd32, 3'd0), 3'd3, 1'b1, pass ? ~pattern : pattern);
      for (op = 0; op < 7; op++) begin
        for (off = 0; off < 8; off += (1 << (op % 4))) begin
          runAccess(lineAddr(8'd32, 3'(off)), 3'(op), 1'b0, 64'd0);
        end
      end
    end
    reportTest("load extension", errsBefore);

    errsBefore = errCount;
    runAccess(lineAddr(8'd40, 3'd0), 3'd3, 1'b1, {$random(seed), $random(seed)});
    for (int sz = 1; sz < 4; sz++) begin
      for (off = 0; off < 8; off++) begin
        if (alignFault(3'(sz), 3'(off))) begin
          runAccess(lineAddr(8'd40, 3'(off)), 3'(sz), 1'b0, 64'd0);
          runAccess(lineAddr(8'd40, 3'(off)), 3'(sz), 1'b1, {$random(seed), $random(seed)});
        end
      end
    end
    runAccess(lineAddr(8'd40, 3'd0), 3'd3, 1'b0, 64'd0);
    reportTest("misaligned refusal", errsBefore);

    errsBefore = errCount;
    for (idx = 0; idx < 16; idx++) begin
      runAccess(lineAddr(8'(idx), 3'd0), 3'd3, 1'b1, {$random(seed), $random(seed)});
    end
    for (int n = 0; n < 200; n++) begin
      isSt = $random(seed) & 1;
      op   = isSt ? ($unsigned($random(seed)) % 4) : ($unsigned($random(seed)) % 7);
      off  = ($unsigned($random(seed)) % 8) & ~((1 << (op % 4)) - 1);
      idx  = $unsigned($random(seed)) % 16;
      runAccess(lineAddr(8'(idx), 3'(off)), 3'(op), isSt, {$random(seed), $random(seed)});
    end
    reportTest("random mix", errsBefore);

    $display("tests ok %0d, tests failed %0d", testsPassed, testsFailed);
    if (errCount == 0 && testsFailed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== lsuSubsys.f ====
lsuOpPkg.sv
lsuBusPkg.sv
lsuCtrl.sv
loadAlign.sv
storeMerge.sv
dataRam.sv
lsuTop.sv
tb_lsuTop.sv

// ==== Bender.yml ====
package:
  name: lsuSubsys

sources:
  - lsuOpPkg.sv
  - lsuBusPkg.sv
  - lsuCtrl.sv
  - loadAlign.sv
  - storeMerge.sv
  - dataRam.sv
  - lsuTop.sv
  - target: simulation
    files:
      - tb_lsuTop.sv
